/* vdma_write.f */
logic/vdma_axi_pkg.sv
logic/vdma_frame_pkg.sv
logic/stream_reg_slice.sv
logic/axi_burst_writer.sv
logic/vdma_write_core.sv
logic/vdma_write_top.sv
tb/vdma_write_assert.sv
tb/vdma_write_checker.sv
tb/tb_vdma_write.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_vdma_write -f vdma_write.f || exit 1
out=$(./obj_dir/Vtb_vdma_write)
echo "$out"
echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

/* tb/tb_vdma_write.sv */
`timescale 1ns/100ps

module tb_vdma_write;
	import vdma_axi_pkg::*;
	import vdma_frame_pkg::*;

	typedef struct packed {
		addr_t   addr;
		stride_t stride;
		hsize_t  width;
		vsize_t  height;
		count_t  size;
		len_t    awlen;
		logic    update;
		int      junk;
		logic    throttle;
		int      words;
	} row_t;

	localparam int NUM_ROWS = 7;

	logic    aclk;
	logic    aresetn;
	logic    ctl_enable;
	logic    ctl_update;
	logic    ctl_busy;
	index_t  ctl_index;
	addr_t   param_addr;
	stride_t param_stride;
	hsize_t  param_width;
	vsize_t  param_height;
	count_t  param_size;
	len_t    param_awlen;
	addr_t   monitor_addr;
	stride_t monitor_stride;
	hsize_t  monitor_width;
	vsize_t  monitor_height;
	count_t  monitor_size;
	len_t    monitor_awlen;
	data_t   s_tdata;
	logic    s_tuser;
	logic    s_tvalid;
	logic    s_tready;
	addr_t   awaddr;
	len_t    awlen;
	logic    awvalid;
	logic    awready;
	data_t   wdata;
	logic    wlast;
	logic    wvalid;
	logic    wready;
	resp_t   bresp;
	logic    bvalid;
	logic    bready;
	int      errors;
	int      checks;

	row_t        table_q [NUM_ROWS];
	int          seed;
	int          limit;
	int          cycles;
	int          failed_rows;
	logic        throttle;
	logic        burst_done;
	logic [31:0] rnd;
	data_t       pixel;

	vdma_write_top uut (.*);

	vdma_write_checker chk (.*);

	bind vdma_write_top vdma_write_assert u_assert (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.ctl_busy (ctl_busy),
		.awaddr   (awaddr),
		.awlen    (awlen),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wlast    (wlast),
		.wvalid   (wvalid),
		.wready   (wready)
	);

	initial aclk = 1'b0;
	always #20 aclk = ~aclk;

	// ------------------------------
	// memory side
	// ------------------------------

	always @(negedge aclk) begin
		burst_done = wvalid && wready && wlast;
	end

	always @(posedge aclk) begin
		#2;
		bvalid = burst_done && aresetn;
		if (throttle) begin
			rnd     = $random(seed);
			awready = (rnd[1:0] != 2'b00);
			wready  = (rnd[3:2] != 2'b00);
		end else begin
			awready = 1'b1;
			wready  = 1'b1;
		end
	end

	always @(posedge aclk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// addr, stride, width, height, size, awlen, update, junk, throttle, words
	task automatic fill_table();
		table_q[0] = '{32'h1000_0000, 14'h100, 12'd16, 12'd4, 24'd0, 8'd7, 1'b1, 0, 1'b0, 64};
		table_q[1] = '{32'h2000_0040, 14'h80, 12'd21, 12'd3, 24'd0, 8'd7, 1'b1, 3, 1'b0, 63};
		// contiguous, pitch equals width
		table_q[2] = '{32'h3000_0000, 14'd40, 12'd10, 12'd6, 24'd60, 8'd15, 1'b1, 2, 1'b0, 60};
		table_q[3] = '{32'hdead_0000, 14'h20, 12'd3, 12'd2, 24'd0, 8'd1, 1'b0, 1, 1'b0, 60};
		table_q[4] = '{32'h4000_0100, 14'h200, 12'd37, 12'd5, 24'd0, 8'd15, 1'b1, 4, 1'b1, 185};
		// size set but pitch too wide, so still line mode
		table_q[5] = '{32'h5000_0000, 14'h40, 12'd12, 12'd4, 24'd48, 8'd0, 1'b1, 0, 1'b1, 48};
		table_q[6] = '{32'h0000_0000, 14'h4, 12'd1, 12'd1, 24'd5, 8'd9, 1'b0, 2, 1'b1, 48};
	endtask

	// called 2 ns after an edge, returns 2 ns after the accepting edge
	task automatic send_beat(input data_t data, input logic user);
		s_tdata  = data;
		s_tuser  = user;
		s_tvalid = 1'b1;
		@(negedge aclk);
		while (!s_tready) begin
			@(negedge aclk);
		end
		@(posedge aclk);
		#2;
		s_tvalid = 1'b0;
	endtask

	task automatic run_row(input row_t row, input int r);
		int k;
		throttle = row.throttle;
		// beat while idle, dropped by the core
		send_beat(data_t'(32'hee00_0000 + r), 1'b1);
		repeat (3) @(posedge aclk);
		#2;
		param_addr   = row.addr;
		param_stride = row.stride;
		param_width  = row.width;
		param_height = row.height;
		param_size   = row.size;
		param_awlen  = row.awlen;
		ctl_update   = row.update;
		ctl_enable   = 1'b1;
		@(posedge aclk);
		#2;
		ctl_enable = 1'b0;
		for (k = 0; k < row.junk; k++) begin
			send_beat(data_t'(32'hbad0_0000 + k), 1'b0);
		end
		for (k = 0; k < row.words; k++) begin
			send_beat(pixel, k == 0);
			pixel = pixel + data_t'(1);
		end
		@(negedge aclk);
		while (ctl_busy) begin
			@(negedge aclk);
		end
		@(posedge aclk);
		#2;
	endtask

	initial begin
		int total;
		int r;
		int err_before;
		seed         = 15;
		cycles       = 0;
		failed_rows  = 0;
		pixel        = '0;
		throttle     = 1'b0;
		burst_done   = 1'b0;
		aresetn      = 1'b0;
		ctl_enable   = 1'b0;
		ctl_update   = 1'b0;
		param_addr   = '0;
		param_stride = '0;
		param_width  = '0;
		param_height = '0;
		param_size   = '0;
		param_awlen  = '0;
		s_tdata      = '0;
		s_tuser      = 1'b0;
		s_tvalid     = 1'b0;
		awready      = 1'b1;
		wready       = 1'b1;
		bresp        = 2'b00;
		bvalid       = 1'b0;
		fill_table();
		total = 0;
		for (r = 0; r < NUM_ROWS; r++) begin
			total = total + table_q[r].words;
		end
		limit = 10 * total + 200 * NUM_ROWS;

		repeat (8) @(posedge aclk);
		#2;
		aresetn = 1'b1;
		repeat (2) @(posedge aclk);
		#2;

		for (r = 0; r < NUM_ROWS; r++) begin
			err_before = errors;
			run_row(table_q[r], r);
			if (errors != err_before) begin
				failed_rows++;
				$display("row %0d: failed with %0d errors", r, errors - err_before);
			end else begin
				$display("row %0d: passed, %0d words", r, table_q[r].words);
			end
		end

		$display("rows %0d, failed %0d, checks %0d, errors %0d",
			NUM_ROWS, failed_rows, checks, errors);
		if (errors == 0 && failed_rows == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb/vdma_write_checker.sv */
`timescale 1ns/100ps

module vdma_write_checker (
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic                    ctl_enable,
	input  logic                    ctl_update,
	input  logic                    ctl_busy,
	input  vdma_frame_pkg::index_t  ctl_index,
	input  vdma_axi_pkg::addr_t     param_addr,
	input  vdma_frame_pkg::stride_t param_stride,
	input  vdma_frame_pkg::hsize_t  param_width,
	input  vdma_frame_pkg::vsize_t  param_height,
	input  vdma_frame_pkg::count_t  param_size,
	input  vdma_axi_pkg::len_t      param_awlen,
	input  vdma_axi_pkg::addr_t     monitor_addr,
	input  vdma_frame_pkg::stride_t monitor_stride,
	input  vdma_frame_pkg::hsize_t  monitor_width,
	input  vdma_frame_pkg::vsize_t  monitor_height,
	input  vdma_frame_pkg::count_t  monitor_size,
	input  vdma_axi_pkg::len_t      monitor_awlen,
	input  vdma_axi_pkg::addr_t     awaddr,
	input  vdma_axi_pkg::len_t      awlen,
	input  logic                    awvalid,
	input  logic                    awready,
	input  vdma_axi_pkg::data_t     wdata,
	input  logic                    wlast,
	input  logic                    wvalid,
	input  logic                    wready,
	input  logic                    bvalid,
	input  logic                    bready,
	output int                      errors,
	output int                      checks
);
	import vdma_axi_pkg::*;
	import vdma_frame_pkg::*;

	// own copy of the frame geometry
	addr_t   sh_addr;
	stride_t sh_stride;
	hsize_t  sh_width;
	vsize_t  sh_height;
	count_t  sh_size;
	len_t    sh_awlen;

	addr_t   exp_addr_q[$];
	len_t    exp_len_q[$];
	int      frames;
	int      exp_beats;
	int      got_beats;
	int      burst_beat;
	len_t    cur_len;
	data_t   next_pixel;
	logic    busy_q;

	initial begin
		errors     = 0;
		checks     = 0;
		frames     = 0;
		next_pixel = '0;
		busy_q     = 1'b0;
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERROR %s expected %h got %h", name, exp, act);
		end
	endtask

	// ------------------------------
	// expected bursts of one frame
	// ------------------------------

	task automatic plan_frame();
		int    lines;
		int    count;
		int    rem;
		int    beats;
		int    l;
		addr_t a;
		if ((sh_size != '0) && (int'(sh_width) * 4 == int'(sh_stride))) begin
			lines = 1;
			count = int'(sh_size);
		end else begin
			lines = int'(sh_height);
			count = int'(sh_width);
		end
		exp_beats = lines * count;
		for (l = 0; l < lines; l++) begin
			a   = sh_addr + addr_t'(l * int'(sh_stride));
			rem = count;
			while (rem > 0) begin
				beats = (rem > int'(sh_awlen) + 1) ? int'(sh_awlen) + 1 : rem;
				exp_addr_q.push_back(a);
				exp_len_q.push_back(len_t'(beats - 1));
				a   = a + addr_t'(beats * 4);
				rem = rem - beats;
			end
		end
	endtask

	task automatic start_frame();
		if (ctl_update) begin
			sh_addr   = param_addr;
			sh_stride = param_stride;
			sh_width  = param_width;
			sh_height = param_height;
			sh_size   = param_size;
			sh_awlen  = param_awlen;
		end
		frames++;
		got_beats = 0;
		exp_addr_q.delete();
		exp_len_q.delete();
		plan_frame();
	endtask

	task automatic check_burst();
		len_t exp_len;
		if (exp_addr_q.size() == 0) begin
			errors++;
			$display("burst at address %h was not expected", awaddr);
			exp_len = awlen;
		end else begin
			exp_len = exp_len_q.pop_front();
			compare("awaddr", exp_addr_q.pop_front(), awaddr);
			compare("awlen", 32'(exp_len), 32'(awlen));
		end
		cur_len    = exp_len;
		burst_beat = 0;
	endtask

	task automatic check_beat();
		compare("wdata", next_pixel, wdata);
		compare("wlast", 32'(burst_beat == int'(cur_len)), 32'(wlast));
		next_pixel = next_pixel + data_t'(1);
		burst_beat++;
		got_beats++;
	endtask

	task automatic end_frame();
		if (exp_addr_q.size() != 0) begin
			errors++;
			$display("frame %0d ended with %0d bursts never issued", frames, exp_addr_q.size());
		end
		compare("frame_beats", exp_beats, got_beats);
		compare("ctl_index", 32'(frames), 32'(ctl_index));
		compare("monitor_addr", sh_addr, monitor_addr);
		compare("monitor_stride", 32'(sh_stride), 32'(monitor_stride));
		compare("monitor_width", 32'(sh_width), 32'(monitor_width));
		compare("monitor_height", 32'(sh_height), 32'(monitor_height));
		compare("monitor_size", 32'(sh_size), 32'(monitor_size));
		compare("monitor_awlen", 32'(sh_awlen), 32'(monitor_awlen));
	endtask

	// everything here is stable half a cycle before the edge
	always @(negedge aclk) begin
		if (!aresetn) begin
			busy_q = 1'b0;
		end else begin
			if (ctl_enable && !ctl_busy) begin
				start_frame();
			end
			if (awvalid && awready) begin
				check_burst();
			end
			if (wvalid && wready) begin
				check_beat();
			end
			// responses always taken
			if (bvalid) begin
				compare("bready", 32'd1, 32'(bready));
			end
			if (busy_q && !ctl_busy) begin
				end_frame();
			end
			busy_q = ctl_busy;
		end
	end

endmodule

/* tb/vdma_write_assert.sv */
`timescale 1ns/100ps

module vdma_write_assert (
	input logic                aclk,
	input logic                aresetn,
	input logic                ctl_busy,
	input vdma_axi_pkg::addr_t awaddr,
	input vdma_axi_pkg::len_t  awlen,
	input logic                awvalid,
	input logic                awready,
	input vdma_axi_pkg::data_t wdata,
	input logic                wlast,
	input logic                wvalid,
	input logic                wready
);

	// address held until the slave takes it
	aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
		else $error("awvalid dropped or AW payload changed before awready");

	w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
		else $error("wvalid dropped or W payload changed before wready");

	idle_after_reset: assert property (@(posedge aclk) !aresetn |=> !ctl_busy)
		else $error("ctl_busy high after reset");

endmodule

/* logic/vdma_write_top.sv */
`timescale 1ns/100ps

module vdma_write_top (
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic                    ctl_enable,
	input  logic                    ctl_update,
	output logic                    ctl_busy,
	output vdma_frame_pkg::index_t  ctl_index,
	input  vdma_axi_pkg::addr_t     param_addr,
	input  vdma_frame_pkg::stride_t param_stride,
	input  vdma_frame_pkg::hsize_t  param_width,
	input  vdma_frame_pkg::vsize_t  param_height,
	input  vdma_frame_pkg::count_t  param_size,
	input  vdma_axi_pkg::len_t      param_awlen,
	output vdma_axi_pkg::addr_t     monitor_addr,
	output vdma_frame_pkg::stride_t monitor_stride,
	output vdma_frame_pkg::hsize_t  monitor_width,
	output vdma_frame_pkg::vsize_t  monitor_height,
	output vdma_frame_pkg::count_t  monitor_size,
	output vdma_axi_pkg::len_t      monitor_awlen,
	input  vdma_axi_pkg::data_t     s_tdata,
	input  logic                    s_tuser,
	input  logic                    s_tvalid,
	output logic                    s_tready,
	output vdma_axi_pkg::addr_t     awaddr,
	output vdma_axi_pkg::len_t      awlen,
	output logic                    awvalid,
	input  logic                    awready,
	output vdma_axi_pkg::data_t     wdata,
	output logic                    wlast,
	output logic                    wvalid,
	input  logic                    wready,
	input  vdma_axi_pkg::resp_t     bresp,
	input  logic                    bvalid,
	output logic                    bready
);
	import vdma_axi_pkg::*;
	import vdma_frame_pkg::*;

	data_t  st_data;
	logic   st_user;
	logic   st_valid;
	logic   st_ready;
	logic   wr_start;
	addr_t  wr_addr;
	count_t wr_count;
	len_t   wr_maxlen;
	logic   wr_busy;
	data_t  px_data;
	logic   px_valid;
	logic   px_ready;

	stream_reg_slice u_slice (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (s_tdata),
		.s_user  (s_tuser),
		.s_valid (s_tvalid),
		.s_ready (s_tready),
		.m_data  (st_data),
		.m_user  (st_user),
		.m_valid (st_valid),
		.m_ready (st_ready)
	);

	// port names match the wires one to one
	vdma_write_core u_core (.*);

	axi_burst_writer u_writer (.*);

endmodule

/* logic/vdma_write_core.sv */
`timescale 1ns/100ps

module vdma_write_core (
	input  logic                    aclk,
	input  logic                    aresetn,
	input  logic                    ctl_enable,
	input  logic                    ctl_update,
	output logic                    ctl_busy,
	output vdma_frame_pkg::index_t  ctl_index,
	input  vdma_axi_pkg::addr_t     param_addr,
	input  vdma_frame_pkg::stride_t param_stride,
	input  vdma_frame_pkg::hsize_t  param_width,
	input  vdma_frame_pkg::vsize_t  param_height,
	input  vdma_frame_pkg::count_t  param_size,
	input  vdma_axi_pkg::len_t      param_awlen,
	output vdma_axi_pkg::addr_t     monitor_addr,
	output vdma_frame_pkg::stride_t monitor_stride,
	output vdma_frame_pkg::hsize_t  monitor_width,
	output vdma_frame_pkg::vsize_t  monitor_height,
	output vdma_frame_pkg::count_t  monitor_size,
	output vdma_axi_pkg::len_t      monitor_awlen,
	input  vdma_axi_pkg::data_t     st_data,
	input  logic                    st_user,
	input  logic                    st_valid,
	output logic                    st_ready,
	output logic                    wr_start,
	output vdma_axi_pkg::addr_t     wr_addr,
	output vdma_frame_pkg::count_t  wr_count,
	output vdma_axi_pkg::len_t      wr_maxlen,
	input  logic                    wr_busy,
	output vdma_axi_pkg::data_t     px_data,
	output logic                    px_valid,
	input  logic                    px_ready
);
	import vdma_axi_pkg::*;
	import vdma_frame_pkg::*;

	core_state_t state;
	logic        wait_fs;
	logic        start_q;
	index_t      index_q;

	// shadow registers
	addr_t       sh_addr;
	stride_t     sh_stride;
	hsize_t      sh_width;
	vsize_t      sh_height;
	count_t      sh_size;
	len_t        sh_awlen;

	addr_t       line_addr;
	count_t      line_count;
	vsize_t      lines_left;

	addr_t       sel_addr;
	stride_t     sel_stride;
	hsize_t      sel_width;
	vsize_t      sel_height;
	count_t      sel_size;
	logic        contig;
	logic        frame_go;
	logic        line_done;

	// geometry for the frame about to start
	assign sel_addr   = ctl_update ? param_addr : sh_addr;
	assign sel_stride = ctl_update ? param_stride : sh_stride;
	assign sel_width  = ctl_update ? param_width : sh_width;
	assign sel_height = ctl_update ? param_height : sh_height;
	assign sel_size   = ctl_update ? param_size : sh_size;
	assign contig     = (sel_size != '0) && ((stride_t'(sel_width) << DATA_SIZE) == sel_stride);

	assign frame_go  = (state == IDLE) && ctl_enable;
	assign line_done = (state == LINE_WAIT) && !start_q && !wr_busy;

	// ------------------------------
	// frame and line control
	// ------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state   <= IDLE;
			wait_fs <= 1'b0;
			start_q <= 1'b0;
			index_q <= '0;
		end else begin
			start_q <= 1'b0;
			case (state)
				IDLE: begin
					if (ctl_enable) begin
						state   <= LINE_WAIT;
						start_q <= 1'b1;
						index_q <= index_q + index_t'(1);
					end
				end
				LINE_START: begin
					start_q <= 1'b1;
					state   <= LINE_WAIT;
				end
				LINE_WAIT: begin
					if (line_done) begin
						state <= (lines_left <= vsize_t'(1)) ? IDLE : LINE_START;
					end
				end
				default: state <= IDLE;
			endcase

			// hold off until the tuser beat
			if (state == IDLE) begin
				wait_fs <= ctl_enable;
			end else if (st_valid && st_user) begin
				wait_fs <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (frame_go) begin
			if (ctl_update) begin
				sh_addr   <= param_addr;
				sh_stride <= param_stride;
				sh_width  <= param_width;
				sh_height <= param_height;
				sh_size   <= param_size;
				sh_awlen  <= param_awlen;
			end
			line_addr  <= sel_addr;
			line_count <= contig ? sel_size : count_t'(sel_width);
			lines_left <= contig ? vsize_t'(1) : sel_height;
		end
		if (line_done) begin
			line_addr  <= line_addr + addr_t'(sh_stride);
			lines_left <= lines_left - vsize_t'(1);
		end
	end

	assign ctl_busy  = (state != IDLE);
	assign ctl_index = index_q;

	assign monitor_addr   = sh_addr;
	assign monitor_stride = sh_stride;
	assign monitor_width  = sh_width;
	assign monitor_height = sh_height;
	assign monitor_size   = sh_size;
	assign monitor_awlen  = sh_awlen;

	assign wr_start  = start_q;
	assign wr_addr   = line_addr;
	assign wr_count  = line_count;
	assign wr_maxlen = sh_awlen;

	// idle or waiting beats are dropped here
	assign px_data  = st_data;
	assign px_valid = st_valid && ctl_busy && (!wait_fs || st_user);
	assign st_ready = !ctl_busy || (wr_busy && px_ready);

endmodule

/* logic/axi_burst_writer.sv */
`timescale 1ns/100ps

module axi_burst_writer (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   wr_start,
	input  vdma_axi_pkg::addr_t    wr_addr,
	input  vdma_frame_pkg::count_t wr_count,
	input  vdma_axi_pkg::len_t     wr_maxlen,
	output logic                   wr_busy,
	input  vdma_axi_pkg::data_t    px_data,
	input  logic                   px_valid,
	output logic                   px_ready,
	output vdma_axi_pkg::addr_t    awaddr,
	output vdma_axi_pkg::len_t     awlen,
	output logic                   awvalid,
	input  logic                   awready,
	output vdma_axi_pkg::data_t    wdata,
	output logic                   wlast,
	output logic                   wvalid,
	input  logic                   wready,
	input  vdma_axi_pkg::resp_t    bresp,
	input  logic                   bvalid,
	output logic                   bready
);
	import vdma_axi_pkg::*;
	import vdma_frame_pkg::*;

	wr_state_t state;
	addr_t     addr_q;
	count_t    remain_q;
	len_t      maxlen_q;
	len_t      beat_cnt;
	count_t    pending;

	count_t    max_beats;
	len_t      burst_len;
	count_t    burst_beats;
	logic      aw_fire;
	logic      w_fire;
	logic      b_fire;

	// ------------------------------
	// burst sizing
	// ------------------------------

	assign max_beats   = count_t'(maxlen_q) + count_t'(1);
	assign burst_len   = (remain_q > max_beats) ? maxlen_q : len_t'(remain_q - count_t'(1));
	assign burst_beats = count_t'(burst_len) + count_t'(1);

	assign awaddr  = addr_q;
	assign awlen   = burst_len;
	assign awvalid = (state == W_ADDR);

	// W beats straight from the pixel path
	assign wdata    = px_data;
	assign wvalid   = (state == W_DATA) && px_valid;
	assign wlast    = (state == W_DATA) && (beat_cnt == '0);
	assign px_ready = (state == W_DATA) && wready;

	assign bready  = 1'b1;
	assign wr_busy = (state != W_IDLE);

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	// responses are only counted, bresp is not inspected
	assign b_fire  = bvalid && bready;

	// ------------------------------
	// state and response count
	// ------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state   <= W_IDLE;
			pending <= '0;
		end else begin
			case (state)
				W_IDLE: begin
					if (wr_start) begin
						state <= (wr_count == '0) ? W_DRAIN : W_ADDR;
					end
				end
				W_ADDR: begin
					if (aw_fire) begin
						state <= W_DATA;
					end
				end
				W_DATA: begin
					if (w_fire && wlast) begin
						state <= (remain_q == '0) ? W_DRAIN : W_ADDR;
					end
				end
				W_DRAIN: begin
					if (pending == '0) begin
						state <= W_IDLE;
					end
				end
				default: state <= W_IDLE;
			endcase

			if (aw_fire && !b_fire) begin
				pending <= pending + count_t'(1);
			end else if (b_fire && !aw_fire) begin
				pending <= pending - count_t'(1);
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (state == W_IDLE && wr_start) begin
			addr_q   <= wr_addr;
			remain_q <= wr_count;
			maxlen_q <= wr_maxlen;
		end
		if (aw_fire) begin
			addr_q   <= addr_q + (addr_t'(burst_beats) << DATA_SIZE);
			remain_q <= remain_q - burst_beats;
			beat_cnt <= burst_len;
		end
		if (w_fire && !wlast) begin
			beat_cnt <= beat_cnt - len_t'(1);
		end
	end

endmodule

/* logic/stream_reg_slice.sv */
`timescale 1ns/100ps

module stream_reg_slice (
	input  logic                aclk,
	input  logic                aresetn,
	input  vdma_axi_pkg::data_t s_data,
	input  logic                s_user,
	input  logic                s_valid,
	output logic                s_ready,
	output vdma_axi_pkg::data_t m_data,
	output logic                m_user,
	output logic                m_valid,
	input  logic                m_ready
);
	import vdma_axi_pkg::*;

	data_t main_data;
	logic  main_user;
	logic  main_valid;
	data_t spare_data;
	logic  spare_user;
	logic  spare_valid;
	logic  main_load;

	// main register free to take a new beat
	assign main_load = !main_valid || m_ready;

	assign m_data  = main_data;
	assign m_user  = main_user;
	assign m_valid = main_valid;
	assign s_ready = !spare_valid;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			main_valid  <= 1'b0;
			spare_valid <= 1'b0;
		end else if (main_load) begin
			main_valid  <= spare_valid || s_valid;
			spare_valid <= 1'b0;
		end else if (s_valid && s_ready) begin
			// main stalled, park the beat
			spare_valid <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (main_load) begin
			main_data <= spare_valid ? spare_data : s_data;
			main_user <= spare_valid ? spare_user : s_user;
		end
		if (!main_load && s_valid && s_ready) begin
			spare_data <= s_data;
			spare_user <= s_user;
		end
	end

endmodule

/* logic/vdma_frame_pkg.sv */
package vdma_frame_pkg;

	localparam int H_WIDTH      = 12;
	localparam int V_WIDTH      = 12;
	localparam int STRIDE_WIDTH = 14;
	localparam int COUNT_WIDTH  = H_WIDTH + V_WIDTH;
	localparam int INDEX_WIDTH  = 8;

	typedef logic [H_WIDTH-1:0]      hsize_t;
	typedef logic [V_WIDTH-1:0]      vsize_t;
	typedef logic [STRIDE_WIDTH-1:0] stride_t;
	// line width or whole frame, in words
	typedef logic [COUNT_WIDTH-1:0]  count_t;
	typedef logic [INDEX_WIDTH-1:0]  index_t;

	typedef enum logic [1:0] {IDLE, LINE_START, LINE_WAIT} core_state_t;
	typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_DRAIN} wr_state_t;

endpackage

/* logic/vdma_axi_pkg.sv */
package vdma_axi_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------

	// log2 of bytes per word
	localparam int DATA_SIZE  = 2;
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 8 << DATA_SIZE;
	localparam int LEN_WIDTH  = 8;
	localparam int RESP_WIDTH = 2;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// burst length minus one
	typedef logic [LEN_WIDTH-1:0]  len_t;
	typedef logic [RESP_WIDTH-1:0] resp_t;

endpackage
